//--- logic/note_visual_macros.svh
`ifndef NOTE_VISUAL_MACROS_SVH
`define NOTE_VISUAL_MACROS_SVH

// ------------------------------
// Screen geometry
// ------------------------------

`define NV_SCREEN_WIDTH   640
`define NV_SCREEN_HEIGHT  480

// ------------------------------
// Note recognition
// ------------------------------

// Sample magnitude that counts as clearly high or clearly low
`define NV_HYSTERESIS     4096

// Semitones C4 to B4 in centi-hertz
`define NV_NOTE_FREQ_0    26163
`define NV_NOTE_FREQ_1    27718
`define NV_NOTE_FREQ_2    29366
`define NV_NOTE_FREQ_3    31113
`define NV_NOTE_FREQ_4    32963
`define NV_NOTE_FREQ_5    34923
`define NV_NOTE_FREQ_6    36999
`define NV_NOTE_FREQ_7    39200
`define NV_NOTE_FREQ_8    41530
`define NV_NOTE_FREQ_9    44000
`define NV_NOTE_FREQ_10   46616
`define NV_NOTE_FREQ_11   49388

// Window half width in thousandths of the nominal period
`define NV_TOL_PERMIL     20

`define NV_PERIOD_WIDTH   24

`endif

//--- logic/note_visual_pkg.sv
`include "note_visual_macros.svh"

package note_visual_pkg;

    // ------------------------------
    // Audio side
    // ------------------------------

    typedef logic signed [23:0]                  sample_t;
    typedef logic        [`NV_PERIOD_WIDTH - 1:0] period_t;

    // 0 to 11 are C4 to B4, 15 means no note
    typedef logic [3:0] note_t;

    // Segments a to g, then the dot in the lowest bit
    typedef logic [7:0] segments_t;

    typedef enum logic [1:0]
    {
        wait_low,
        wait_high,
        measure
    } rec_state_t;

    // ------------------------------
    // Video side
    // ------------------------------

    typedef logic [9:0] pixel_x_t;
    typedef logic [8:0] pixel_y_t;
    typedef logic [3:0] color_t;

    typedef struct packed
    {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    typedef struct packed
    {
        pixel_x_t sweep;
        pixel_y_t level;
    } anim_state_t;

    typedef logic [3:0] key_t;

endpackage

//--- logic/note_recognizer.sv
`timescale 1ns/1ps

`include "note_visual_macros.svh"

module note_recognizer
#(
    parameter clk_mhz = 50
)
(
    input  logic                        clk,
    input  logic                        rst,

    input  note_visual_pkg::sample_t    mic,

    output logic                        note_vld,
    output note_visual_pkg::note_t      note,
    output note_visual_pkg::segments_t  abcdefgh
);

    localparam int                     n_notes = 12;
    localparam note_visual_pkg::note_t no_note = 4'd15;

    // ------------------------------
    // Note tables
    // ------------------------------

    function automatic int note_freq(input int idx);
        case (idx)
            0:       return `NV_NOTE_FREQ_0;
            1:       return `NV_NOTE_FREQ_1;
            2:       return `NV_NOTE_FREQ_2;
            3:       return `NV_NOTE_FREQ_3;
            4:       return `NV_NOTE_FREQ_4;
            5:       return `NV_NOTE_FREQ_5;
            6:       return `NV_NOTE_FREQ_6;
            7:       return `NV_NOTE_FREQ_7;
            8:       return `NV_NOTE_FREQ_8;
            9:       return `NV_NOTE_FREQ_9;
            10:      return `NV_NOTE_FREQ_10;
            default: return `NV_NOTE_FREQ_11;
        endcase
    endfunction

    // Letters C C. d d. E F F. G G. A A. b, dot for the sharps
    function automatic note_visual_pkg::segments_t seg_pattern
    (
        input note_visual_pkg::note_t n
    );
        case (n)
            4'd0:    return 8'b1001_1100;
            4'd1:    return 8'b1001_1101;
            4'd2:    return 8'b0111_1010;
            4'd3:    return 8'b0111_1011;
            4'd4:    return 8'b1001_1110;
            4'd5:    return 8'b1000_1110;
            4'd6:    return 8'b1000_1111;
            4'd7:    return 8'b1011_1100;
            4'd8:    return 8'b1011_1101;
            4'd9:    return 8'b1110_1110;
            4'd10:   return 8'b1110_1111;
            4'd11:   return 8'b0011_1110;
            default: return 8'b0000_0000;
        endcase
    endfunction

    // ------------------------------
    // Crossing detector and period counter
    // ------------------------------

    note_visual_pkg::rec_state_t state;
    note_visual_pkg::period_t    cnt;
    note_visual_pkg::note_t      prev_note;
    note_visual_pkg::note_t      match;
    logic                        armed;
    logic [n_notes - 1:0]        hit;

    wire is_high  = (mic >= `NV_HYSTERESIS);
    wire is_low   = (mic <= -(`NV_HYSTERESIS));
    wire cnt_full = (cnt == '1);

    // A new rising crossing closes the period held in cnt
    wire crossing = (state == note_visual_pkg::measure) & armed & is_high;

    // One tolerance window per semitone, sized at elaboration
    for (genvar i = 0; i < n_notes; i++)
    begin : g_window
        localparam longint nom = longint'(clk_mhz) * 100_000_000 / note_freq(i);
        localparam longint tol = nom * `NV_TOL_PERMIL / 1000;

        assign hit[i] = (cnt >= note_visual_pkg::period_t'(nom - tol))
                      & (cnt <= note_visual_pkg::period_t'(nom + tol));
    end

    always_comb
    begin
        match = no_note;

        for (int i = n_notes - 1; i >= 0; i--)
            if (hit[i])
                match = note_visual_pkg::note_t'(i);
    end

    // ------------------------------
    // Recognizer FSM
    // ------------------------------

    always_ff @(posedge clk)
        if (rst)
        begin
            state     <= note_visual_pkg::wait_low;
            armed     <= 1'b0;
            cnt       <= '0;
            prev_note <= no_note;
            note_vld  <= 1'b0;
        end
        else
        begin
            note_vld <= 1'b0;

            case (state)
                note_visual_pkg::wait_low:
                    if (is_low)
                        state <= note_visual_pkg::wait_high;

                // First crossing starts the count but closes no period
                note_visual_pkg::wait_high:
                    if (is_high)
                    begin
                        state     <= note_visual_pkg::measure;
                        armed     <= 1'b0;
                        cnt       <= note_visual_pkg::period_t'(1);
                        prev_note <= no_note;
                    end

                note_visual_pkg::measure:
                    if (cnt_full)
                    begin
                        // Signal lost, start over
                        state     <= note_visual_pkg::wait_low;
                        prev_note <= no_note;
                    end
                    else if (crossing)
                    begin
                        cnt       <= note_visual_pkg::period_t'(1);
                        armed     <= 1'b0;
                        prev_note <= match;

                        // Two periods in a row on the same note
                        if (match != no_note && match == prev_note)
                            note_vld <= 1'b1;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;

                        if (is_low)
                            armed <= 1'b1;
                    end

                default:
                    state <= note_visual_pkg::wait_low;
            endcase
        end

    always_ff @(posedge clk)
        if (crossing)
            note <= match;

    // ------------------------------
    // Seven-segment register
    // ------------------------------

    always_ff @(posedge clk)
        if (rst)
            abcdefgh <= '0;
        else if (note_vld)
            abcdefgh <= seg_pattern(note);

endmodule

//--- logic/animation_counters.sv
`timescale 1ns/1ps

`include "note_visual_macros.svh"

module animation_counters
#(
    parameter w_tick = 20
)
(
    input  logic                          clk,
    input  logic                          rst,

    input  note_visual_pkg::key_t         key,

    output note_visual_pkg::anim_state_t  anim
);

    localparam note_visual_pkg::pixel_x_t sweep_last =
        note_visual_pkg::pixel_x_t'(`NV_SCREEN_WIDTH - 1);

    localparam note_visual_pkg::pixel_y_t level_last =
        note_visual_pkg::pixel_y_t'(`NV_SCREEN_HEIGHT - 1);

    localparam note_visual_pkg::pixel_y_t level_mid =
        note_visual_pkg::pixel_y_t'(`NV_SCREEN_HEIGHT / 2);

    // ------------------------------
    // Tick divider
    // ------------------------------

    logic [w_tick - 1:0] tick_cnt;

    always_ff @(posedge clk)
        if (rst)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;

    // First tick lands right after reset
    wire tick = (tick_cnt == '0);

    // ------------------------------
    // Next sweep and level
    // ------------------------------

    note_visual_pkg::pixel_x_t sweep_next;
    note_visual_pkg::pixel_y_t level_next;

    always_comb
    begin
        if (anim.sweep == sweep_last)
            sweep_next = '0;
        else
            sweep_next = anim.sweep + 1'b1;

        // Key 0 pushes up, any other key pulls down
        if (anim.level == '0 || anim.level == level_last)
            level_next = level_mid;
        else
            level_next = note_visual_pkg::pixel_y_t'(anim.level
                       + note_visual_pkg::pixel_y_t'(key[0])
                       - note_visual_pkg::pixel_y_t'(|key[3:1]));
    end

    always_ff @(posedge clk)
        if (rst)
        begin
            anim.sweep <= '0;
            anim.level <= level_mid;
        end
        else if (tick)
        begin
            anim.sweep <= sweep_next;
            anim.level <= level_next;
        end

endmodule

//--- logic/pattern_painter.sv
`timescale 1ns/1ps

`include "note_visual_macros.svh"

module pattern_painter
(
    input  note_visual_pkg::pixel_x_t     x,
    input  note_visual_pkg::pixel_y_t     y,

    input  note_visual_pkg::note_t        note,
    input  note_visual_pkg::anim_state_t  anim,

    output note_visual_pkg::rgb_t         rgb
);

    localparam int hyper_limit  = (`NV_SCREEN_WIDTH * `NV_SCREEN_HEIGHT) / 4;
    localparam int circle_limit = (`NV_SCREEN_WIDTH * `NV_SCREEN_HEIGHT) / 10;

    // ------------------------------
    // Geometry relative to the moving point
    // ------------------------------

    logic signed [10:0] dx;
    logic signed [9:0]  dy;
    logic signed [20:0] prod;
    logic signed [20:0] prod_abs;
    logic signed [21:0] dx_sq;
    logic signed [21:0] dy_sq;
    logic signed [21:0] dist_sq;
    logic        [8:0]  sum_xy;
    logic        [8:0]  diff_xy;

    assign dx       = $signed({1'b0, x}) - $signed({1'b0, anim.sweep});
    assign dy       = $signed({1'b0, y}) - $signed({1'b0, anim.level});

    assign prod     = dx * dy;
    assign prod_abs = (prod < 0) ? -prod : prod;

    assign dx_sq    = dx * dx;
    assign dy_sq    = dy * dy;
    assign dist_sq  = dx_sq + dy_sq;

    // Low 9 bits cover every channel fed by x+y or x-y
    assign sum_xy   = 9'(x) + 9'(y);
    assign diff_xy  = 9'(x) - 9'(y);

    // ------------------------------
    // Figure choice by note modulo 3
    // ------------------------------

    always_comb
    begin
        rgb = '0;

        case (note)
            4'd0, 4'd3, 4'd6, 4'd9:
                // Bar that grows with the sweep
                if (x < anim.sweep)
                begin
                    rgb.red   = sum_xy[8:5];
                    rgb.green = diff_xy[8:5];
                    rgb.blue  = x[3:0];
                end

            4'd1, 4'd4, 4'd7, 4'd10:
                if (prod_abs < hyper_limit)
                begin
                    rgb.red   = x[3:0];
                    rgb.green = y[3:0];
                    rgb.blue  = '1;
                end

            4'd2, 4'd5, 4'd8, 4'd11:
                if (dist_sq < circle_limit)
                begin
                    rgb.red   = '1;
                    rgb.green = '1;
                    rgb.blue  = sum_xy[3:0];
                end

            // No note paints black
            default:
                rgb = '0;
        endcase
    end

endmodule

//--- logic/lab_top.sv
`timescale 1ns/1ps

module lab_top
#(
    parameter clk_mhz = 50,
    parameter w_tick  = 20
)
(
    input  logic                        clk,
    input  logic                        rst,

    // Keys, switches, LEDs
    input  note_visual_pkg::key_t       key,
    input  logic [7:0]                  sw,
    output logic [7:0]                  led,

    output note_visual_pkg::segments_t  abcdefgh,

    // Microphone
    input  note_visual_pkg::sample_t    mic,

    // Pixel in, color out
    input  note_visual_pkg::pixel_x_t   x,
    input  note_visual_pkg::pixel_y_t   y,
    output note_visual_pkg::rgb_t       rgb
);

    // ------------------------------
    // Note recognition
    // ------------------------------

    logic                         note_vld;
    note_visual_pkg::note_t       note;
    note_visual_pkg::note_t       sticky_note;

    note_recognizer
    #(
        .clk_mhz (clk_mhz)
    )
    i_note_recognizer
    (
        .clk      (clk),
        .rst      (rst),
        .mic      (mic),
        .note_vld (note_vld),
        .note     (note),
        .abcdefgh (abcdefgh)
    );

    // Last recognized note stays until the next one
    always_ff @(posedge clk)
        if (rst)
            sticky_note <= '0;
        else if (note_vld)
            sticky_note <= note;

    assign led = {4'b0000, sticky_note};

    // ------------------------------
    // Animation and painting
    // ------------------------------

    note_visual_pkg::anim_state_t anim;

    animation_counters
    #(
        .w_tick (w_tick)
    )
    i_animation_counters
    (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .anim (anim)
    );

    pattern_painter i_pattern_painter
    (
        .x    (x),
        .y    (y),
        .note (sticky_note),
        .anim (anim),
        .rgb  (rgb)
    );

endmodule

//--- test/tb_lab_top.sv
`timescale 1ns/1ps

`include "note_visual_macros.svh"

module tb_lab_top;

    localparam int clk_mhz     = 1;
    localparam int w_tick      = 6;
    localparam int tick_cycles = 1 << w_tick;
    localparam int screen_w    = `NV_SCREEN_WIDTH;
    localparam int screen_h    = `NV_SCREEN_HEIGHT;

    // Longest period any wave test drives in clock cycles
    localparam int max_period  = 4000;
    localparam int idle_cycles = 4000;
    localparam int hold_cycles = 500;
    localparam int wave_cycles = idle_cycles + 4 * max_period + hold_cycles + 100;

    // 5 recognitions, 5 rejections, 3 figure setups
    localparam int n_wave_tests = 13;
    localparam int anim_ticks   = 4 * 200 + 480 + 480;
    localparam int pixel_checks = 16 + 50 + 3 * 200;
    localparam int cycle_limit  = n_wave_tests * wave_cycles + anim_ticks * tick_cycles
                                + pixel_checks + 1000;

    logic                        clk;
    logic                        rst;
    note_visual_pkg::key_t       key;
    logic [7:0]                  sw;
    logic [7:0]                  led;
    note_visual_pkg::segments_t  abcdefgh;
    note_visual_pkg::sample_t    mic;
    note_visual_pkg::pixel_x_t   x;
    note_visual_pkg::pixel_y_t   y;
    note_visual_pkg::rgb_t       rgb;

    lab_top
    #(
        .clk_mhz (clk_mhz),
        .w_tick  (w_tick)
    )
    UUT
    (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .mic      (mic),
        .x        (x),
        .y        (y),
        .rgb      (rgb)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Random numbers
    // ------------------------------

    logic [31:0] rng_state = 32'h868d_2d3e;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_random() % 32'(hi - lo + 1));
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------

    int note_freq_tbl [12] = '{`NV_NOTE_FREQ_0, `NV_NOTE_FREQ_1, `NV_NOTE_FREQ_2,
                               `NV_NOTE_FREQ_3, `NV_NOTE_FREQ_4, `NV_NOTE_FREQ_5,
                               `NV_NOTE_FREQ_6, `NV_NOTE_FREQ_7, `NV_NOTE_FREQ_8,
                               `NV_NOTE_FREQ_9, `NV_NOTE_FREQ_10, `NV_NOTE_FREQ_11};

    byte note_letters [12] = '{"C", "C", "d", "d", "E", "F", "F", "G", "G", "A", "A", "b"};

    // Clock cycles per period from centi-hertz
    function automatic int nominal_period(input int idx);
        return int'(longint'(clk_mhz) * 100_000_000 / note_freq_tbl[idx]);
    endfunction

    function automatic int expected_match(input int period);
        int nom;
        int tol;
        for (int i = 0; i < 12; i++)
        begin
            nom = nominal_period(i);
            tol = nom * `NV_TOL_PERMIL / 1000;
            if (period >= nom - tol && period <= nom + tol)
                return i;
        end
        return 15;
    endfunction

    // Bit 7 is segment a and bit 0 the dot
    function automatic note_visual_pkg::segments_t letter_segments(input byte letter);
        case (letter)
            "A":     return 8'b1110_1110;
            "b":     return 8'b0011_1110;
            "C":     return 8'b1001_1100;
            "d":     return 8'b0111_1010;
            "E":     return 8'b1001_1110;
            "F":     return 8'b1000_1110;
            "G":     return 8'b1011_1100;
            default: return 8'b0000_0000;
        endcase
    endfunction

    function automatic note_visual_pkg::segments_t expected_segments(input int n);
        logic sharp;
        sharp = (n == 1 || n == 3 || n == 6 || n == 8 || n == 10);
        return letter_segments(note_letters[n]) | {7'b0, sharp};
    endfunction

    function automatic note_visual_pkg::rgb_t paint_model
    (
        input int px,
        input int py,
        input int n,
        input int sweep,
        input int level
    );
        note_visual_pkg::rgb_t c;
        int dx;
        int dy;
        int p;
        c  = '0;
        dx = px - sweep;
        dy = py - level;
        if (n < 12)
            case (n % 3)
                0:
                    if (px < sweep)
                    begin
                        c.red   = 4'((px + py) >>> 5);
                        c.green = 4'((px - py) >>> 5);
                        c.blue  = 4'(px);
                    end
                1:
                begin
                    p = dx * dy;
                    if (p < 0)
                        p = -p;
                    if (p < screen_w * screen_h / 4)
                        c = {4'(px), 4'(py), 4'hf};
                end
                default:
                    if (dx * dx + dy * dy < screen_w * screen_h / 10)
                        c = {4'hf, 4'hf, 4'(px + py)};
            endcase
        return c;
    endfunction

    // Cycle-accurate copy of the tick divider and animation registers
    logic [w_tick - 1:0]        m_tick;
    note_visual_pkg::pixel_x_t  m_sweep;
    note_visual_pkg::pixel_y_t  m_level;
    note_visual_pkg::note_t     m_sticky   = '0;
    note_visual_pkg::segments_t m_segments = '0;
    int                         m_wraps    = 0;
    int                         m_snaps    = 0;

    always @(posedge clk)
        if (rst)
        begin
            m_tick  <= '0;
            m_sweep <= '0;
            m_level <= 9'(screen_h / 2);
        end
        else
        begin
            m_tick <= m_tick + 1'b1;
            if (m_tick == 0)
            begin
                if (int'(m_sweep) == screen_w - 1)
                begin
                    m_sweep <= '0;
                    m_wraps <= m_wraps + 1;
                end
                else
                    m_sweep <= m_sweep + 1'b1;

                if (m_level == 0 || int'(m_level) == screen_h - 1)
                begin
                    m_level <= 9'(screen_h / 2);
                    m_snaps <= m_snaps + 1;
                end
                else if (key[0] && key[3:1] == 3'b000)
                    m_level <= m_level + 1'b1;
                else if (!key[0] && key[3:1] != 3'b000)
                    m_level <= m_level - 1'b1;
            end
        end

    // ------------------------------
    // Checks and failure handling
    // ------------------------------

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_rgb
    (
        input string                 name,
        input note_visual_pkg::rgb_t expected,
        input note_visual_pkg::rgb_t actual
    );
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h (x %0d, y %0d)",
                     name, expected, actual, x, y);
            abort_run();
        end
    endtask

    task automatic check_note
    (
        input string                  name,
        input note_visual_pkg::note_t expected,
        input note_visual_pkg::note_t actual
    );
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_segments
    (
        input string                      name,
        input note_visual_pkg::segments_t expected,
        input note_visual_pkg::segments_t actual
    );
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    int cycle_count = 0;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: no end of the run after %0d cycles", cycle_count);
            abort_run();
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------

    // Half the pixels land near the moving point so the figures get hit
    task automatic drive_random_pixel();
        int px;
        int py;
        if ((next_random() & 32'd1) != 0)
        begin
            px = int'(m_sweep) + rand_range(-128, 127);
            py = int'(m_level) + rand_range(-128, 127);
            px = (px + screen_w) % screen_w;
            py = (py + screen_h) % screen_h;
        end
        else
        begin
            px = rand_range(0, screen_w - 1);
            py = rand_range(0, screen_h - 1);
        end
        x <= note_visual_pkg::pixel_x_t'(px);
        y <= note_visual_pkg::pixel_y_t'(py);
    endtask

    task automatic check_pixels(input string name, input int n);
        note_visual_pkg::rgb_t expected;
        repeat (n)
        begin
            @(posedge clk);
            drive_random_pixel();
            @(negedge clk);
            expected = paint_model(int'(x), int'(y), int'(m_sticky),
                                   int'(m_sweep), int'(m_level));
            check_rgb(name, expected, rgb);
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            mic <= '0;
        end
    endtask

    // Square wave with the low half first so each period ends on a rising edge
    task automatic drive_wave(input int period, input int amp, input int n);
        int low_len;
        low_len = period - period / 2;
        repeat (n)
        begin
            repeat (low_len)
            begin
                @(posedge clk);
                mic <= note_visual_pkg::sample_t'(-amp);
            end
            repeat (period / 2)
            begin
                @(posedge clk);
                mic <= note_visual_pkg::sample_t'(amp);
            end
        end
    endtask

    task automatic recognize_note(input string name, input int idx);
        int period;
        period = nominal_period(idx) * (1000 + rand_range(-10, 10)) / 1000;
        idle(idle_cycles);
        drive_wave(period, 20000, 3);
        @(negedge clk);
        m_sticky   = note_visual_pkg::note_t'(idx);
        m_segments = expected_segments(idx);
        check_note(name, m_sticky, led[3:0]);
        check_note({name, "_led_upper"}, '0, led[7:4]);
        check_segments(name, m_segments, abcdefgh);

        idle(hold_cycles);
        @(negedge clk);
        check_note({name, "_hold"}, m_sticky, led[3:0]);
        check_segments({name, "_hold"}, m_segments, abcdefgh);
    endtask

    task automatic reject_wave(input string name, input int period, input int amp);
        idle(idle_cycles);
        drive_wave(period, amp, 4);
        @(negedge clk);
        check_note(name, m_sticky, led[3:0]);
        check_segments(name, m_segments, abcdefgh);
    endtask

    task automatic anim_block(input string name, input note_visual_pkg::key_t k, input int ticks);
        @(posedge clk);
        key <= k;
        check_pixels(name, ticks * tick_cycles - 1);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial
    begin
        int idx;
        int period;

        rst = 1'b1;
        key = '0;
        sw  = '0;
        mic = '0;
        x   = '0;
        y   = '0;

        // Reset held for 16 cycles
        @(posedge clk);
        sw <= 8'(next_random());
        check_pixels("reset_pixels", 14);
        @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_note("reset_led", '0, led[3:0]);
        check_note("reset_led_upper", '0, led[7:4]);
        check_segments("reset_segments", '0, abcdefgh);
        check_pixels("reset_state_pixels", 50);

        repeat (5)
            recognize_note("recognition", rand_range(0, 11));

        // Neither neighbor of the midway period is the note already shown
        repeat (3)
        begin
            idx = rand_range(0, 10);
            while (idx == int'(m_sticky) || idx + 1 == int'(m_sticky))
                idx = rand_range(0, 10);
            period = (nominal_period(idx) + nominal_period(idx + 1)) / 2;
            if (expected_match(period) != 15)
            begin
                $display("Midway period %0d falls inside a note window", period);
                abort_run();
            end
            reject_wave("reject_midway", period, 20000);
        end

        repeat (2)
            reject_wave("reject_in_band",
                        nominal_period((int'(m_sticky) + rand_range(1, 11)) % 12),
                        rand_range(1000, `NV_HYSTERESIS - 1));

        // One note per figure in the order bar, hyperbola and circle
        for (int r = 0; r < 3; r++)
        begin
            recognize_note("paint_setup", 3 * rand_range(0, 3) + r);
            check_pixels("paint_figure", 200);
        end

        repeat (4)
            anim_block("anim_random_keys", note_visual_pkg::key_t'(next_random()), 200);
        anim_block("anim_up", 4'b0001, 480);
        anim_block("anim_down", note_visual_pkg::key_t'(2 * rand_range(1, 7)), 480);

        if (m_wraps == 0 || m_snaps < 2)
        begin
            $display("Animation missed the sweep wrap or the level snap");
            abort_run();
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+logic
logic/note_visual_pkg.sv
logic/note_recognizer.sv
logic/animation_counters.sv
logic/pattern_painter.sv
logic/lab_top.sv
test/tb_lab_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the lab_top testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_lab_top \
    -f files.f \
    -o sim_tb_lab_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb_lab_top
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0
